// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bpu
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/bpu_assertions.sv ====
module bpu_assertions (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 stall_i,
  input logic                 res_valid_i,
  input bpu_pkg::resolution_t res_i,
  input logic                 fetch_valid_i,
  input bpu_pkg::fetch_req_t  fetch_i
);

  import bpu_pkg::*;

  // Mispredict strobe from execute
  logic            redirect;
  // Corrected address of a redirect in this cycle
  logic [XLEN-1:0] fix_pc;
  // Address that must follow the request now on fetch
  logic [XLEN-1:0] next_pc;
  // High once the first valid request went out
  logic            seen_valid_q;

  assign redirect = res_valid_i & res_i.mispredict;
  assign fix_pc   = res_i.taken ? res_i.target : res_i.pc + 32'd4;
  assign next_pc  = fetch_i.pred_taken ? {fetch_i.pred_target, {OFFSET{1'b0}}}
                                       : fetch_i.pc + 32'd4;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seen_valid_q <= 1'b0;
    end else if (fetch_valid_i) begin
      seen_valid_q <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Reset and boot
  // --------------------------------------------------------------------------

  a_reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !fetch_valid_i)
    else $error("fetch valid high while reset is asserted");

  a_reset_exit: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !fetch_valid_i)
    else $error("fetch valid high on the first cycle after reset");

  a_boot_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (fetch_valid_i && !seen_valid_q) |-> fetch_i.pc == BOOT_PC)
    else $error("first fetch address is not the boot address");

  // Reserved bit of a valid request
  a_rsvd_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fetch_valid_i |-> !fetch_i.rsvd)
    else $error("reserved bit of the fetch request is not zero");

  // --------------------------------------------------------------------------
  // Flow, stall and redirect
  // --------------------------------------------------------------------------

  // Sequential or predicted successor
  a_flow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (fetch_valid_i && !stall_i && !redirect) |=> fetch_valid_i && fetch_i.pc == $past(next_pc))
    else $error("fetch address does not follow the previous prediction");

  // Whole output frozen under stall
  a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (stall_i && !redirect) |=> $stable(fetch_valid_i) && $stable(fetch_i))
    else $error("fetch output changed during a stall");

  a_redirect_kill: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    redirect |=> !fetch_valid_i)
    else $error("fetch valid not dropped after a redirect");

  // Corrected address shows one cycle after the kill
  a_redirect_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(redirect) && !redirect && !stall_i) |=> fetch_valid_i && fetch_i.pc == $past(fix_pc, 2))
    else $error("fetch address after a redirect is not the corrected address");

endmodule

bind bpu_top bpu_assertions u_bpu_assertions (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .stall_i      (stall_i),
  .res_valid_i  (res_valid_i),
  .res_i        (res_i),
  .fetch_valid_i(fetch_valid_o),
  .fetch_i      (fetch_o)
);

// ==== bench/tb_bpu.sv ====
module tb_bpu;

  import bpu_pkg::*;

  localparam logic [31:0] SEED = 32'h4e7c;
  // Cycles allowed for an address to reach fetch
  localparam int unsigned WAIT_LIMIT = 20;
  // Trained branch and target away from boot and random traffic
  localparam logic [XLEN-1:0] BR_PC  = 32'h0000_2040;
  localparam logic [XLEN-1:0] BR_TGT = 32'h0000_8000;
  // Same BTB row and same counter as BR_PC but another tag
  localparam logic [XLEN-1:0] ALIAS_PC = BR_PC + 32'h0000_0100;

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        stall;
  logic        res_valid;
  resolution_t res;
  logic        fetch_valid;
  fetch_req_t  fetch;
  fetch_req_t  seen;

  tb_clock u_clock (.clk_o(clk));

  bpu_top dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .flush_i      (flush),
    .stall_i      (stall),
    .res_valid_i  (res_valid),
    .res_i        (res),
    .fetch_valid_o(fetch_valid),
    .fetch_o      (fetch)
  );

  // --------------------------------------------------------------------------
  // Helpers called on a falling edge
  // --------------------------------------------------------------------------

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // One-cycle resolution strobe from execute
  task automatic send_resolution(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] target,
                                 input logic taken, input logic mispredict);
    res.pc         = pc;
    res.target     = target;
    res.taken      = taken;
    res.mispredict = mispredict;
    res_valid      = 1'b1;
    @(negedge clk);
    res_valid = 1'b0;
    res       = '0;
  endtask

  // Mispredicted not-taken branch right before addr
  task automatic steer_to(input logic [XLEN-1:0] addr);
    send_resolution(addr - 32'd4, '0, 1'b0, 1'b1);
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
  endtask

  task automatic wait_for_fetch(input logic [XLEN-1:0] addr, output fetch_req_t req);
    int unsigned cycles;
    cycles = 0;
    while (!(fetch_valid && fetch.pc == addr) && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (fetch_valid && fetch.pc == addr) begin
      req = fetch;
    end else begin
      $display("Timed out waiting for a valid fetch of address 0x%h", addr);
      abort_run();
    end
  endtask

  // Stall bursts, random resolutions and rare flushes
  task automatic run_random_traffic(input int unsigned cycles);
    int unsigned stall_left;
    stall_left = 0;
    repeat (cycles) begin
      if (stall_left == 0 && $urandom % 6 == 0) begin
        stall_left = 1 + $urandom % 5;
      end
      stall = (stall_left != 0);
      if (stall_left != 0) begin
        stall_left--;
      end
      res_valid = ($urandom % 8 == 0);
      res       = '0;
      if (res_valid) begin
        res.pc         = 32'h0000_4000 + (($urandom % 256) << 2);
        res.target     = 32'h0000_4000 + (($urandom % 256) << 2);
        res.taken      = 1'($urandom % 2);
        res.mispredict = 1'($urandom % 2);
      end
      flush = ($urandom % 64 == 0);
      @(negedge clk);
    end
    stall     = 1'b0;
    res_valid = 1'b0;
    res       = '0;
    flush     = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    void'($urandom(SEED));
    rst_n     = 1'b0;
    flush     = 1'b0;
    stall     = 1'b0;
    res_valid = 1'b0;
    res       = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Plain sequential run from the boot address
    repeat (20) @(negedge clk);
    run_random_traffic(400);
    pulse_flush();

    // One taken resolution moves the counter to 10
    send_resolution(BR_PC, BR_TGT, 1'b1, 1'b0);
    steer_to(BR_PC);
    wait_for_fetch(BR_PC, seen);
    check_hex("fetch_o.pred_taken", {31'd0, seen.pred_taken}, 32'd1);
    check_hex("fetch_o.pred_target", {2'b00, seen.pred_target}, BR_TGT >> OFFSET);

    // Tag mismatch on the same row
    steer_to(ALIAS_PC);
    wait_for_fetch(ALIAS_PC, seen);
    check_hex("fetch_o.pred_taken", {31'd0, seen.pred_taken}, 32'd0);

    // Second taken resolution lifts the counter to 11
    send_resolution(BR_PC, BR_TGT, 1'b1, 1'b0);
    // Not taken drops the BTB row while the counter stays taken
    send_resolution(BR_PC, BR_TGT, 1'b0, 1'b0);
    steer_to(BR_PC);
    wait_for_fetch(BR_PC, seen);
    check_hex("fetch_o.pred_taken", {31'd0, seen.pred_taken}, 32'd0);

    // Retrain and then flush both tables
    send_resolution(BR_PC, BR_TGT, 1'b1, 1'b0);
    pulse_flush();
    steer_to(BR_PC);
    wait_for_fetch(BR_PC, seen);
    check_hex("fetch_o.pred_taken", {31'd0, seen.pred_taken}, 32'd0);

    repeat (5) @(negedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
  output logic clk_o
);

  // Half of the 10 unit period
  localparam int unsigned HALF_PERIOD = 5;

  // Free running, starts low
  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

// ==== design/bht.sv ====
module bht (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  input  logic                     res_valid_i,
  input  bpu_pkg::resolution_t     res_i,
  input  logic [bpu_pkg::XLEN-1:0] pc_i,
  output logic                     taken_o
);

  import bpu_pkg::*;

  // Two-bit counters, upper bit is the taken bias
  logic [BHT_ROWS-1:0][1:0] cnt_q;

  // Counter addressed by the resolution and its next value
  logic [BHT_BITS-1:0] wr_idx;
  logic [1:0]          wr_cnt;
  logic [1:0]          nxt_cnt;

  // Counter addressed by the fetch PC
  logic [BHT_BITS-1:0] rd_idx;

  // -------------------------------------------------------------------------
  // Training
  // -------------------------------------------------------------------------

  assign wr_idx = res_i.pc[BHT_BITS+OFFSET-1:OFFSET];
  assign wr_cnt = cnt_q[wr_idx];

  // Saturating step toward the actual outcome
  always_comb begin
    nxt_cnt = wr_cnt;
    if (res_i.taken) begin
      if (wr_cnt != 2'b11) begin
        nxt_cnt = wr_cnt + 2'd1;
      end
    end else begin
      if (wr_cnt != 2'b00) begin
        nxt_cnt = wr_cnt - 2'd1;
      end
    end
  end

  // Reset and flush both return every counter to weakly not taken
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= {BHT_ROWS{CNT_RESET}};
    end else if (flush_i) begin
      cnt_q <= {BHT_ROWS{CNT_RESET}};
    end else if (res_valid_i) begin
      cnt_q[wr_idx] <= nxt_cnt;
    end
  end

  // -------------------------------------------------------------------------
  // Lookup
  // -------------------------------------------------------------------------

  // Indexed by address alone, no history
  assign rd_idx  = pc_i[BHT_BITS+OFFSET-1:OFFSET];

  // States 10 and 11 predict taken
  assign taken_o = cnt_q[rd_idx][1];

endmodule

// ==== design/bpu_pkg.sv ====
package bpu_pkg;

  // -------------------------------------------------------------------------
  // Widths and table sizes
  // -------------------------------------------------------------------------

  // Address width of the core
  localparam int unsigned XLEN = 32;

  // Byte offset bits, always zero for 32-bit instructions
  localparam int unsigned OFFSET = 2;

  // BTB index width, 16 rows
  localparam int unsigned BTB_BITS = 4;
  localparam int unsigned BTB_ROWS = 1 << BTB_BITS;

  // Counter table index width, 64 counters
  localparam int unsigned BHT_BITS = 6;
  localparam int unsigned BHT_ROWS = 1 << BHT_BITS;

  // Tag is what is left above index and offset
  localparam int unsigned TAG_W = XLEN - BTB_BITS - OFFSET;

  // Stored targets are word addresses
  localparam int unsigned TGT_W = XLEN - OFFSET;

  // -------------------------------------------------------------------------
  // Reset values
  // -------------------------------------------------------------------------

  // First fetch address after reset
  localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_1000;

  // Weakly not taken
  localparam logic [1:0] CNT_RESET = 2'b01;

  // -------------------------------------------------------------------------
  // Shared structs
  // -------------------------------------------------------------------------

  // Branch outcome sent back from execute
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] target;
    logic            taken;
    logic            mispredict;
  } resolution_t;

  // Address and prediction handed to instruction fetch
  typedef struct packed {
    logic [XLEN-1:0]  pc;
    logic             pred_taken;
    logic [TGT_W-1:0] pred_target;
    logic             rsvd;
  } fetch_req_t;

endpackage

// ==== design/bpu_top.sv ====
module bpu_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  input  logic                 stall_i,
  input  logic                 res_valid_i,
  input  bpu_pkg::resolution_t res_i,
  output logic                 fetch_valid_o,
  output bpu_pkg::fetch_req_t  fetch_o
);

  import bpu_pkg::*;

  // Fetch address shared by both tables
  logic [XLEN-1:0] pc;

  // Lookup results
  logic             btb_hit;
  logic [TGT_W-1:0] btb_target;
  logic             bht_taken;

  // PC stage toward the fetch register
  fetch_req_t pred;
  logic       redirect;

  // -------------------------------------------------------------------------
  // PC generation
  // -------------------------------------------------------------------------

  pc_gen u_pc_gen (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .stall_i     (stall_i),
    .res_valid_i (res_valid_i),
    .res_i       (res_i),
    .btb_hit_i   (btb_hit),
    .btb_target_i(btb_target),
    .bht_taken_i (bht_taken),
    .pc_o        (pc),
    .pred_o      (pred),
    .redirect_o  (redirect)
  );

  // -------------------------------------------------------------------------
  // Prediction tables, trained straight from execute
  // -------------------------------------------------------------------------

  btb u_btb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .res_valid_i(res_valid_i),
    .res_i      (res_i),
    .pc_i       (pc),
    .hit_o      (btb_hit),
    .target_o   (btb_target)
  );

  bht u_bht (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .res_valid_i(res_valid_i),
    .res_i      (res_i),
    .pc_i       (pc),
    .taken_o    (bht_taken)
  );

  // -------------------------------------------------------------------------
  // Output register
  // -------------------------------------------------------------------------

  fetch_stage u_fetch_stage (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall_i),
    .redirect_i   (redirect),
    .pred_i       (pred),
    .fetch_valid_o(fetch_valid_o),
    .fetch_o      (fetch_o)
  );

endmodule

// ==== design/btb.sv ====
module btb (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  input  logic                      res_valid_i,
  input  bpu_pkg::resolution_t      res_i,
  input  logic [bpu_pkg::XLEN-1:0]  pc_i,
  output logic                      hit_o,
  output logic [bpu_pkg::TGT_W-1:0] target_o
);

  import bpu_pkg::*;

  // One row of payload, the valid bit lives apart
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [TGT_W-1:0] target;
  } btb_entry_t;

  // Per-row valid bits
  logic [BTB_ROWS-1:0] valid_q;

  // Tag and target storage
  btb_entry_t entry_q [BTB_ROWS];

  // Write side
  logic [BTB_BITS-1:0] wr_idx;
  btb_entry_t          wr_entry;

  // Read side
  logic [BTB_BITS-1:0] rd_idx;
  logic [TAG_W-1:0]    rd_tag;
  btb_entry_t          rd_entry;

  // -------------------------------------------------------------------------
  // Update from resolutions
  // -------------------------------------------------------------------------

  // Row and tag come from the resolved branch address
  assign wr_idx         = res_i.pc[BTB_BITS+OFFSET-1:OFFSET];
  assign wr_entry.tag    = res_i.pc[XLEN-1:BTB_BITS+OFFSET];
  assign wr_entry.target = res_i.target[XLEN-1:OFFSET];

  // Taken sets the row valid, not taken drops it
  // Flush wins over a resolution in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (res_valid_i) begin
      valid_q[wr_idx] <= res_i.taken;
    end
  end

  // Payload only matters for taken branches
  always_ff @(posedge clk_i) begin
    if (res_valid_i && res_i.taken) begin
      entry_q[wr_idx] <= wr_entry;
    end
  end

  // -------------------------------------------------------------------------
  // Lookup
  // -------------------------------------------------------------------------

  assign rd_idx   = pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign rd_tag   = pc_i[XLEN-1:BTB_BITS+OFFSET];
  assign rd_entry = entry_q[rd_idx];

  // Hit needs a live row and a matching tag
  assign hit_o    = valid_q[rd_idx] && (rd_entry.tag == rd_tag);

  // Target is passed on even on a miss, pc_gen qualifies it
  assign target_o = rd_entry.target;

endmodule

// ==== design/fetch_stage.sv ====
module fetch_stage (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                stall_i,
  input  logic                redirect_i,
  input  bpu_pkg::fetch_req_t pred_i,
  output logic                fetch_valid_o,
  output bpu_pkg::fetch_req_t fetch_o
);

  // New request is taken only when nothing kills or holds it
  logic load;

  // -------------------------------------------------------------------------
  // Valid flag
  // -------------------------------------------------------------------------

  assign load = !redirect_i && !stall_i;

  // Redirect drops the wrong-path request
  // Stall keeps whatever is there, valid or not
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetch_valid_o <= 1'b0;
    end else if (redirect_i) begin
      fetch_valid_o <= 1'b0;
    end else if (!stall_i) begin
      fetch_valid_o <= 1'b1;
    end
  end

  // -------------------------------------------------------------------------
  // Request register
  // -------------------------------------------------------------------------

  // Address and prediction move together
  // Contents are stale while valid is low
  always_ff @(posedge clk_i) begin
    if (load) begin
      fetch_o <= pred_i;
    end
  end

endmodule

// ==== design/pc_gen.sv ====
module pc_gen (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      stall_i,
  input  logic                      res_valid_i,
  input  bpu_pkg::resolution_t      res_i,
  input  logic                      btb_hit_i,
  input  logic [bpu_pkg::TGT_W-1:0] btb_target_i,
  input  logic                      bht_taken_i,
  output logic [bpu_pkg::XLEN-1:0]  pc_o,
  output bpu_pkg::fetch_req_t       pred_o,
  output logic                      redirect_o
);

  import bpu_pkg::*;

  // Current fetch address and its successor
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_d;

  // Candidate next addresses
  logic [XLEN-1:0] seq_pc;
  logic [XLEN-1:0] fix_pc;
  logic [XLEN-1:0] pred_pc;

  // Control decisions for this cycle
  logic redirect;
  logic pred_taken;

  // -------------------------------------------------------------------------
  // Redirect from execute
  // -------------------------------------------------------------------------

  // Only a wrong prediction forces a redirect
  assign redirect = res_valid_i & res_i.mispredict;

  // Correct path is the real target or the fall-through of the branch
  assign fix_pc = res_i.taken ? res_i.target : res_i.pc + 32'd4;

  // -------------------------------------------------------------------------
  // Prediction
  // -------------------------------------------------------------------------

  // Taken only with a BTB hit and a taken bias
  assign pred_taken = btb_hit_i & bht_taken_i;

  // Word target back to a byte address
  assign pred_pc = {btb_target_i, {OFFSET{1'b0}}};

  assign seq_pc = pc_q + 32'd4;

  // -------------------------------------------------------------------------
  // Next address
  // -------------------------------------------------------------------------

  // Redirect beats stall, stall beats prediction
  always_comb begin
    if (redirect) begin
      pc_d = fix_pc;
    end else if (stall_i) begin
      pc_d = pc_q;
    end else if (pred_taken) begin
      pc_d = pred_pc;
    end else begin
      pc_d = seq_pc;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= BOOT_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  // Request toward the fetch register
  // Target reads as zero when the prediction is not taken
  always_comb begin
    pred_o             = '0;
    pred_o.pc          = pc_q;
    pred_o.pred_taken  = pred_taken;
    pred_o.pred_target = pred_taken ? btb_target_i : '0;
  end

  // Both tables look up the current address
  assign pc_o       = pc_q;
  assign redirect_o = redirect;

endmodule

// ==== src.f ====
design/bpu_pkg.sv
design/btb.sv
design/bht.sv
design/pc_gen.sv
design/fetch_stage.sv
design/bpu_top.sv
bench/tb_clock.sv
bench/bpu_assertions.sv
bench/tb_bpu.sv
